// File: verif/core_shell_stimulus.txt
# Inputs: ten busy dbg irqp nmi raddr_a raddr_b waddr wdata we kreq kvld key nonce dreq dgnt drv amin abus
# Expected: rdata_a rdata_b scr_req key nonce key_valid alert_minor alert_int alert_bus sleep
# All fields hex, one line per clock cycle
0 0 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 1
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 1
0 0 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 0
0 0 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 1
0 0 1 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 0
0 0 0 1 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 0
0 0 0 0 1 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 1
0 1 0 0 0 05 05 05 1234abcd5f 1 0 0 0000 0000 0 0 0 0 0 0000000000 0000000000 0 5eed c0de 1 0 0 0 0
0 1 0 0 0 05 05 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 1234abcd5f 1234abcd5f 0 5eed c0de 1 0 0 0 0
0 1 0 0 0 0a 00 0a 7f0f0f0f01 1 0 0 0000 0000 0 0 0 0 0 0000000000 2a00000000 0 5eed c0de 1 0 0 0 0
0 0 0 0 0 0a 05 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 7f0f0f0f01 1234abcd5f 0 5eed c0de 1 0 0 0 0
0 0 0 0 0 05 05 05 5555555555 1 0 0 0000 0000 0 0 0 0 0 1234abcd5f 1234abcd5f 0 5eed c0de 1 0 0 0 1
0 0 0 0 0 05 05 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 1234abcd5f 1234abcd5f 0 5eed c0de 1 0 0 0 1
0 0 0 0 0 00 00 00 0000000000 0 1 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 5eed c0de 1 0 0 0 1
0 0 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 1 5eed c0de 0 0 0 0 1
0 0 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 1 5eed c0de 0 0 0 0 1
0 0 0 0 0 00 00 00 0000000000 0 0 1 a1b2 0077 0 0 0 0 0 2a00000000 2a00000000 1 5eed c0de 0 0 0 0 1
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 0 1
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 1 1 0 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 1 1 0 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 1 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 1 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 1 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 1 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 1 1 0 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 1 1 0 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 1 0 0 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 1 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 1 1 1 0 0 2a00000000 2a00000000 0 a1b2 0077 1 0 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 1 0 2a00000000 2a00000000 0 a1b2 0077 1 1 0 0 0
0 1 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 1 2a00000000 2a00000000 0 a1b2 0077 1 0 0 1 0
1 0 0 0 0 00 00 00 0000000000 0 0 0 0000 0000 0 0 0 1 1 2a00000000 2a00000000 0 a1b2 0077 1 1 0 1 0
1 0 0 0 0 1f 00 1f 0123456789 1 0 0 0000 0000 0 0 0 0 0 0000000000 2a00000000 0 a1b2 0077 1 0 0 0 1
1 0 0 0 0 1f 00 00 0000000000 0 0 0 0000 0000 0 0 0 0 0 0123456789 2a00000000 0 a1b2 0077 1 0 0 0 1

// File: filelist.f
logic/shell_pkg.sv
logic/core_clock_ctrl.sv
logic/reg_file_ff.sv
logic/scramble_key_ctrl.sv
logic/dside_tracker.sv
logic/core_shell_top.sv
verif/tb_core_shell.sv

// File: Bender.yml
package:
  name: core_shell

sources:
  # Package first, then the blocks, then the top level
  - logic/shell_pkg.sv
  - logic/core_clock_ctrl.sv
  - logic/reg_file_ff.sv
  - logic/scramble_key_ctrl.sv
  - logic/dside_tracker.sv
  - logic/core_shell_top.sv

  # Testbench, reads verif/core_shell_stimulus.txt from the project root
  - target: test
    files:
      - verif/tb_core_shell.sv

// File: verif/tb_core_shell.sv
// Testbench for the core support shell
// Replays one vector per clock cycle from the stimulus file, inputs change on
// the rising edge, the core clock is checked in the high phase and all other
// outputs on the falling edge

module tb_core_shell;

  timeunit 1ns;
  timeprecision 1ps;

  import shell_pkg::*;

  localparam StimFile = "verif/core_shell_stimulus.txt";
  localparam int unsigned NumCols       = 29;
  localparam int unsigned TimeoutMargin = 20;
  localparam int unsigned ClkHalf       = 20;

  // Short reset key and nonce so the vectors stay readable
  localparam scr_key_t   TbKey   = 128'h5eed;
  localparam scr_nonce_t TbNonce = 64'hc0de;

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic       clk;
  logic       rst_n;
  logic       test_en, core_busy, debug_req, irq_pending, irq_nm;
  rf_addr_t   rf_raddr_a, rf_raddr_b, rf_waddr;
  rf_data_t   rf_wdata;
  logic       rf_we;
  logic       key_req, key_valid;
  scr_key_t   key_in;
  scr_nonce_t nonce_in;
  logic       data_req, data_gnt, data_rvalid;
  logic       alert_minor_in, alert_bus_in;

  rf_data_t   rf_rdata_a, rf_rdata_b;
  logic       scramble_req, scr_key_valid;
  scr_key_t   scr_key;
  scr_nonce_t scr_nonce;
  logic       alert_minor, alert_internal, alert_bus;
  logic       clk_core, core_sleep;

  // Next inputs and expected outputs of the current vector
  logic       nxt_test_en, nxt_busy, nxt_debug, nxt_irq, nxt_nmi;
  rf_addr_t   nxt_raddr_a, nxt_raddr_b, nxt_waddr;
  rf_data_t   nxt_wdata;
  logic       nxt_we, nxt_key_req, nxt_key_valid;
  scr_key_t   nxt_key;
  scr_nonce_t nxt_nonce;
  logic       nxt_data_req, nxt_data_gnt, nxt_data_rvalid;
  logic       nxt_alert_minor, nxt_alert_bus;

  rf_data_t   exp_rdata_a, exp_rdata_b;
  logic       exp_scr_req, exp_key_valid;
  scr_key_t   exp_key;
  scr_nonce_t exp_nonce;
  logic       exp_alert_minor, exp_alert_internal, exp_alert_bus, exp_sleep;

  // Core clock level expected in the high phase of the current cycle
  logic       exp_clk_core;

  string      vectors[$];
  int         vec_idx;
  int         cycle_cnt;

  core_shell_top #(
    .NumWords      (32),
    .MaxOutstanding(2),
    .RndKey        (TbKey),
    .RndNonce      (TbNonce)
  ) i_core_shell_top (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .test_en_i             (test_en),
    .core_busy_i           (core_busy),
    .debug_req_i           (debug_req),
    .irq_pending_i         (irq_pending),
    .irq_nm_i              (irq_nm),
    .rf_raddr_a_i          (rf_raddr_a),
    .rf_raddr_b_i          (rf_raddr_b),
    .rf_waddr_i            (rf_waddr),
    .rf_wdata_i            (rf_wdata),
    .rf_we_i               (rf_we),
    .rf_rdata_a_o          (rf_rdata_a),
    .rf_rdata_b_o          (rf_rdata_b),
    .ic_scr_key_req_i      (key_req),
    .scramble_key_valid_i  (key_valid),
    .scramble_key_i        (key_in),
    .scramble_nonce_i      (nonce_in),
    .scramble_req_o        (scramble_req),
    .scr_key_o             (scr_key),
    .scr_nonce_o           (scr_nonce),
    .scr_key_valid_o       (scr_key_valid),
    .data_req_i            (data_req),
    .data_gnt_i            (data_gnt),
    .data_rvalid_i         (data_rvalid),
    .core_alert_minor_i    (alert_minor_in),
    .core_alert_major_bus_i(alert_bus_in),
    .alert_minor_o         (alert_minor),
    .alert_major_internal_o(alert_internal),
    .alert_major_bus_o     (alert_bus),
    .clk_core_o            (clk_core),
    .core_sleep_o          (core_sleep)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic compare_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h in vector %0d",
                         name, actual, expected, vec_idx));
    end
  endtask

  // Inputs first, then the expected outputs, all hex
  task automatic parse_vector(input string line, output int n_items);
    n_items = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                      nxt_test_en, nxt_busy, nxt_debug, nxt_irq, nxt_nmi,
                      nxt_raddr_a, nxt_raddr_b, nxt_waddr, nxt_wdata, nxt_we,
                      nxt_key_req, nxt_key_valid, nxt_key, nxt_nonce,
                      nxt_data_req, nxt_data_gnt, nxt_data_rvalid,
                      nxt_alert_minor, nxt_alert_bus,
                      exp_rdata_a, exp_rdata_b, exp_scr_req, exp_key, exp_nonce,
                      exp_key_valid, exp_alert_minor, exp_alert_internal,
                      exp_alert_bus, exp_sleep);
  endtask

  task automatic load_vectors();
    int    fd;
    int    n_items;
    int    line_no;
    string line;
    line_no = 0;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      stop_run($sformatf("Could not open the stimulus file %s", StimFile));
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        // Blank lines and column notes carry no vector
        if (line.len() > 1 && line.getc(0) != "#") begin
          parse_vector(line, n_items);
          if (n_items != NumCols) begin
            stop_run($sformatf("Stimulus line %0d has %0d readable fields, it needs %0d",
                               line_no, n_items, NumCols));
          end else begin
            vectors.push_back(line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_inputs();
    test_en        <= nxt_test_en;
    core_busy      <= nxt_busy;
    debug_req      <= nxt_debug;
    irq_pending    <= nxt_irq;
    irq_nm         <= nxt_nmi;
    rf_raddr_a     <= nxt_raddr_a;
    rf_raddr_b     <= nxt_raddr_b;
    rf_waddr       <= nxt_waddr;
    rf_wdata       <= nxt_wdata;
    rf_we          <= nxt_we;
    key_req        <= nxt_key_req;
    key_valid      <= nxt_key_valid;
    key_in         <= nxt_key;
    nonce_in       <= nxt_nonce;
    data_req       <= nxt_data_req;
    data_gnt       <= nxt_data_gnt;
    data_rvalid    <= nxt_data_rvalid;
    alert_minor_in <= nxt_alert_minor;
    alert_bus_in   <= nxt_alert_bus;
  endtask

  task automatic check_outputs();
    compare_value("rf_rdata_a_o", rf_rdata_a, exp_rdata_a);
    compare_value("rf_rdata_b_o", rf_rdata_b, exp_rdata_b);
    compare_value("scramble_req_o", scramble_req, exp_scr_req);
    compare_value("scr_key_o", scr_key, exp_key);
    compare_value("scr_nonce_o", scr_nonce, exp_nonce);
    compare_value("scr_key_valid_o", scr_key_valid, exp_key_valid);
    compare_value("alert_minor_o", alert_minor, exp_alert_minor);
    compare_value("alert_major_internal_o", alert_internal, exp_alert_internal);
    compare_value("alert_major_bus_o", alert_bus, exp_alert_bus);
    compare_value("core_sleep_o", core_sleep, exp_sleep);
  endtask

  //////////////////////////////////////////////////
  // Clock, watchdog and vector replay
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #(ClkHalf) clk = ~clk;
    end
  end

  initial begin : watchdog
    int cycle_limit;
    cycle_cnt = 0;
    @(posedge clk);
    cycle_limit = vectors.size() + TimeoutMargin;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    stop_run($sformatf("Timeout, the stimulus did not finish within %0d cycles", cycle_limit));
  end

  initial begin
    int n_items;
    rst_n          = 1'b0;
    test_en        = 1'b0;
    core_busy      = 1'b0;
    debug_req      = 1'b0;
    irq_pending    = 1'b0;
    irq_nm         = 1'b0;
    rf_raddr_a     = '0;
    rf_raddr_b     = '0;
    rf_waddr       = '0;
    rf_wdata       = '0;
    rf_we          = 1'b0;
    key_req        = 1'b0;
    key_valid      = 1'b0;
    key_in         = '0;
    nonce_in       = '0;
    data_req       = 1'b0;
    data_gnt       = 1'b0;
    data_rvalid    = 1'b0;
    alert_minor_in = 1'b0;
    alert_bus_in   = 1'b0;
    vec_idx        = 0;
    // Last reset cycle is asleep with the test enable low
    exp_clk_core   = 1'b0;

    load_vectors();
    if (vectors.size() == 0) begin
      stop_run("The stimulus file holds no vectors");
    end else begin
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < vectors.size(); i++) begin
        @(posedge clk);
        vec_idx = i + 1;
        parse_vector(vectors[i], n_items);
        drive_inputs();
        #(ClkHalf / 2);
        compare_value("clk_core_o", clk_core, exp_clk_core);
        @(negedge clk);
        check_outputs();
        // Next edge passes after an awake cycle or with the test enable set
        exp_clk_core = !exp_sleep || nxt_test_en;
      end
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// File: logic/core_shell_top.sv
// Support shell around an external RV32 core
// Provides the gated core clock, the register file, the scramble key
// exchange and a data-bus check, and merges their alerts with the core's

module core_shell_top #(
  parameter int unsigned           NumWords       = 32,
  parameter int unsigned           MaxOutstanding = 2,
  parameter shell_pkg::scr_key_t   RndKey         = shell_pkg::ScrKeyDefault,
  parameter shell_pkg::scr_nonce_t RndNonce       = shell_pkg::ScrNonceDefault
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  test_en_i,

  // Sleep and wake
  input  logic                  core_busy_i,
  input  logic                  debug_req_i,
  input  logic                  irq_pending_i,
  input  logic                  irq_nm_i,

  // Register file
  input  shell_pkg::rf_addr_t   rf_raddr_a_i,
  input  shell_pkg::rf_addr_t   rf_raddr_b_i,
  input  shell_pkg::rf_addr_t   rf_waddr_i,
  input  shell_pkg::rf_data_t   rf_wdata_i,
  input  logic                  rf_we_i,
  output shell_pkg::rf_data_t   rf_rdata_a_o,
  output shell_pkg::rf_data_t   rf_rdata_b_o,

  // Scramble key provider
  input  logic                  ic_scr_key_req_i,
  input  logic                  scramble_key_valid_i,
  input  shell_pkg::scr_key_t   scramble_key_i,
  input  shell_pkg::scr_nonce_t scramble_nonce_i,
  output logic                  scramble_req_o,
  output shell_pkg::scr_key_t   scr_key_o,
  output shell_pkg::scr_nonce_t scr_nonce_o,
  output logic                  scr_key_valid_o,

  // Observed data bus and core alerts
  input  logic                  data_req_i,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic                  core_alert_minor_i,
  input  logic                  core_alert_major_bus_i,

  output logic                  alert_minor_o,
  output logic                  alert_major_internal_o,
  output logic                  alert_major_bus_o,
  output logic                  clk_core_o,
  output logic                  core_sleep_o
);

  logic clk_core;
  logic rf_err;
  logic dside_err;

  core_clock_ctrl i_core_clock_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .clk_core_o   (clk_core),
    .core_sleep_o (core_sleep_o)
  );

  assign clk_core_o = clk_core;

  //////////////////////////////////////////////////
  // Register file and data-bus check
  //////////////////////////////////////////////////

  reg_file_ff #(
    .NumWords(NumWords)
  ) i_reg_file_ff (
    .clk_i    (clk_core),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o),
    .err_o    (rf_err)
  );

  // Bus accesses only advance while the core clock runs
  dside_tracker #(
    .MaxOutstanding(MaxOutstanding)
  ) i_dside_tracker (
    .clk_i        (clk_core),
    .rst_ni       (rst_ni),
    .data_req_i   (data_req_i),
    .data_gnt_i   (data_gnt_i),
    .data_rvalid_i(data_rvalid_i),
    .err_o        (dside_err)
  );

  //////////////////////////////////////////////////
  // Scramble key exchange
  //////////////////////////////////////////////////

  scramble_key_ctrl #(
    .RndKey  (RndKey),
    .RndNonce(RndNonce)
  ) i_scramble_key_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .key_req_i     (ic_scr_key_req_i),
    .key_valid_i   (scramble_key_valid_i),
    .key_i         (scramble_key_i),
    .nonce_i       (scramble_nonce_i),
    .key_o         (scr_key_o),
    .nonce_o       (scr_nonce_o),
    .key_valid_o   (scr_key_valid_o),
    .scramble_req_o(scramble_req_o)
  );

  // Alert merge
  assign alert_major_internal_o = rf_err;
  assign alert_major_bus_o      = core_alert_major_bus_i | dside_err;
  assign alert_minor_o          = core_alert_minor_i;

endmodule

// File: logic/dside_tracker.sv
// Outstanding-access monitor for the data bus of the core
// Counts granted requests still waiting for a response and raises err_o
// on a response with nothing pending or a request beyond MaxOutstanding

module dside_tracker #(
  parameter int unsigned MaxOutstanding = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic data_req_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic err_o
);

  localparam int unsigned CntW = $clog2(MaxOutstanding + 1);

  logic [CntW-1:0] cnt_q, cnt_d;
  logic            none_pending;
  logic            all_pending;
  logic            err_resp;
  logic            err_req;
  logic            do_inc;
  logic            do_dec;

  assign none_pending = (cnt_q == '0);
  assign all_pending  = (cnt_q == CntW'(MaxOutstanding));

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  // A response in the same cycle frees a slot for the new request
  assign err_resp = data_rvalid_i & none_pending;
  assign err_req  = data_req_i & all_pending & ~data_rvalid_i;
  assign err_o    = err_resp | err_req;

  //////////////////////////////////////////////////
  // Pending counter
  //////////////////////////////////////////////////

  // Keep the count in range even while flagging an error
  assign do_inc = data_req_i & data_gnt_i & ~err_req;
  assign do_dec = data_rvalid_i & ~none_pending;

  always_comb begin
    cnt_d = cnt_q;
    if (do_inc && !do_dec) begin
      cnt_d = cnt_q + 1'b1;
    end else if (do_dec && !do_inc) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// File: logic/scramble_key_ctrl.sv
// Scramble key and nonce holder with the request exchange toward the key provider
// A key request from the instruction cache invalidates the key and raises
// scramble_req_o until the provider answers with key_valid_i

module scramble_key_ctrl #(
  parameter shell_pkg::scr_key_t   RndKey   = shell_pkg::ScrKeyDefault,
  parameter shell_pkg::scr_nonce_t RndNonce = shell_pkg::ScrNonceDefault
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  key_req_i,
  input  logic                  key_valid_i,
  input  shell_pkg::scr_key_t   key_i,
  input  shell_pkg::scr_nonce_t nonce_i,
  output shell_pkg::scr_key_t   key_o,
  output shell_pkg::scr_nonce_t nonce_o,
  output logic                  key_valid_o,
  output logic                  scramble_req_o
);

  import shell_pkg::*;

  scr_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ScrKeyValid: begin
        if (key_req_i) begin
          state_d = ScrKeyRequest;
        end
      end
      ScrKeyRequest: begin
        if (key_valid_i) begin
          state_d = ScrKeyValid;
        end
      end
      default: state_d = ScrKeyValid;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ScrKeyValid;
    end else begin
      state_q <= state_d;
    end
  end

  // Provider may push a key at any time, not only when asked
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_o   <= RndKey;
      nonce_o <= RndNonce;
    end else if (key_valid_i) begin
      key_o   <= key_i;
      nonce_o <= nonce_i;
    end
  end

  assign key_valid_o    = (state_q == ScrKeyValid);
  assign scramble_req_o = (state_q == ScrKeyRequest);

endmodule

// File: logic/reg_file_ff.sv
// Flip-flop register file with two read ports and one write port
// Runs on the gated core clock, reads are combinational and register zero
// returns the encoded zero word; err_o flags a corrupted write decode

module reg_file_ff #(
  parameter int unsigned NumWords = 32
) (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  shell_pkg::rf_addr_t raddr_a_i,
  input  shell_pkg::rf_addr_t raddr_b_i,
  input  shell_pkg::rf_addr_t waddr_i,
  input  shell_pkg::rf_data_t wdata_i,
  input  logic                we_i,

  output shell_pkg::rf_data_t rdata_a_o,
  output shell_pkg::rf_data_t rdata_b_o,
  output logic                err_o
);

  import shell_pkg::*;

  logic [NumWords-1:0] we_dec;
  rf_data_t            rf_reg [NumWords];

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////

  always_comb begin
    for (int unsigned i = 0; i < NumWords; i++) begin
      we_dec[i] = we_i && (waddr_i == rf_addr_t'(i));
    end
  end

  // At most one enable may be set, anything else means a glitch
  assign err_o = |(we_dec & (we_dec - 1'b1));

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Word zero has no storage
  assign rf_reg[0] = RfWordZeroVal;

  for (genvar i = 1; i < NumWords; i++) begin : gen_word
    rf_data_t word_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        word_q <= '0;
      end else if (we_dec[i]) begin
        word_q <= wdata_i;
      end
    end

    assign rf_reg[i] = word_q;
  end

  // Read ports
  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

endmodule

// File: logic/core_clock_ctrl.sv
// Core clock gating for the processor shell
// The registered busy flag and the wake sources open a latch-based gate on
// clk_i; test_en_i forces the gate open for scan

module core_clock_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clk_core_o,
  output logic core_sleep_o
);

  logic core_busy_q;
  logic clock_en;
  logic gate_en;
  logic gate_en_q;

  // Busy flag from the core, one cycle late
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the core running
  assign clock_en     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  //////////////////////////////////////////////////
  // Clock gate
  //////////////////////////////////////////////////

  assign gate_en = clock_en | test_en_i;

  // Transparent in the low phase, holds through the high phase
  always_latch begin
    if (!clk_i) begin
      gate_en_q <= gate_en;
    end
  end

  assign clk_core_o = clk_i & gate_en_q;

endmodule

// File: logic/shell_pkg.sv
// Shared widths, types and reset constants of the core support shell
// Imported by the register file and the scramble key block, and named
// in module headers wherever a port carries one of these types

package shell_pkg;

  // Data word of the external core
  typedef logic [31:0] word_t;

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  // Seven check bits ride along with every stored word
  localparam int unsigned RfCheckW = 7;
  localparam int unsigned RfDataW  = $bits(word_t) + RfCheckW;

  typedef logic [4:0]         rf_addr_t;
  typedef logic [RfDataW-1:0] rf_data_t;

  // Encoded zero word returned for register zero
  localparam rf_data_t RfWordZeroVal = 39'h2A00000000;

  //////////////////////////////////////////////////
  // Scrambling
  //////////////////////////////////////////////////

  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  typedef logic [ScrKeyW-1:0]   scr_key_t;
  typedef logic [ScrNonceW-1:0] scr_nonce_t;

  // Key and nonce in use until the provider delivers a fresh pair
  localparam scr_key_t   ScrKeyDefault   = 128'h4d2c91f03a7eb615c8d02f94e17a5b63;
  localparam scr_nonce_t ScrNonceDefault = 64'h9e3f0c6a71d2b845;

  typedef enum logic {
    ScrKeyValid   = 1'b0,
    ScrKeyRequest = 1'b1
  } scr_state_e;

endpackage
